/* dv/ex_checker.sv */
`timescale 1ns/1ps

module ex_checker import ex_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            op_valid_i,
    input  logic [XLEN-1:0] op_a_i,
    input  logic [XLEN-1:0] op_b_i,
    input  alu_op_e         op_alu_i,
    input  br_op_e          op_br_i,
    input  logic [XLEN-1:0] op_pc_i,
    input  logic [XLEN-1:0] op_imm_i,
    input  logic            op_credit_i,
    input  logic            res_valid_i,
    input  logic [XLEN-1:0] res_data_i,
    input  logic            res_redirect_i,
    input  logic [XLEN-1:0] res_target_i,
    input  logic            res_credit_i,
    output int              err_count_o,
    output int              checked_o,
    output int              credit_pulses_o,
    output int              pending_o
);

    logic [XLEN-1:0] q_a   [$];
    logic [XLEN-1:0] q_b   [$];
    alu_op_e         q_alu [$];
    br_op_e          q_br  [$];
    logic [XLEN-1:0] q_pc  [$];
    logic [XLEN-1:0] q_imm [$];
    int              outstanding;

    // signed order from the sign bits, then magnitude
    function automatic logic signed_lt(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        if (a[XLEN-1] != b[XLEN-1]) begin
            return a[XLEN-1];
        end
        return (a < b);
    endfunction

    function automatic logic [XLEN-1:0] model_alu(input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b,
                                                  input alu_op_e op);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return {{(XLEN-1){1'b0}}, signed_lt(a, b)};
            ALU_SLTU: return {{(XLEN-1){1'b0}}, (a < b)};
            ALU_SRL:  return a >> b[SHAMT_W-1:0];
            ALU_SLL:  return a << b[SHAMT_W-1:0];
            default:  return '0;
        endcase
    endfunction

    function automatic logic model_taken(input logic [XLEN-1:0] a,
                                         input logic [XLEN-1:0] b,
                                         input br_op_e op);
        case (op)
            BR_BEQ:  return (a == b);
            BR_BNE:  return (a != b);
            BR_BLT:  return signed_lt(a, b);
            BR_BGE:  return !signed_lt(a, b);
            BR_BLTU: return (a < b);
            BR_BGEU: return !(a < b);
            BR_JAL:  return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic compare(input string sig, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] got);
        if (exp !== got) begin
            $display("ERR t=%0t %s expected %h got %h", $time, sig, exp, got);
            err_count_o++;
        end
    endtask

    // outputs sampled before the edge updates them
    always @(posedge clk_i) begin : scoreboard
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] exp_data;
        alu_op_e         alu;
        br_op_e          br;
        if (!rst_n_i) begin
            q_a.delete();
            q_b.delete();
            q_alu.delete();
            q_br.delete();
            q_pc.delete();
            q_imm.delete();
            outstanding = 0;
        end else begin
            // issue credit comes back with the result of the same op
            if (op_credit_i !== res_valid_i) begin
                $display("%0t: op_credit_o pulse not in step with res_valid_o", $time);
                err_count_o++;
            end
            if (res_valid_i) begin
                if (q_a.size() == 0) begin
                    $display("%0t: result appeared with no operation outstanding", $time);
                    err_count_o++;
                end else begin
                    a   = q_a.pop_front();
                    b   = q_b.pop_front();
                    alu = q_alu.pop_front();
                    br  = q_br.pop_front();
                    pc  = q_pc.pop_front();
                    exp_data = (br == BR_JAL) ? pc + 32'd4 : model_alu(a, b, alu);
                    compare("res_data_o", exp_data, res_data_i);
                    compare("res_redirect_o", {31'b0, model_taken(a, b, br)},
                            {31'b0, res_redirect_i});
                    compare("res_target_o", pc + q_imm.pop_front(), res_target_i);
                    checked_o++;
                end
                outstanding++;
            end
            if (res_credit_i) begin
                outstanding--;
            end
            if (outstanding > RES_CREDITS) begin
                $display("%0t: more than %0d results outstanding", $time, RES_CREDITS);
                err_count_o++;
            end
            if (op_credit_i) begin
                credit_pulses_o++;
            end
            if (op_valid_i) begin
                q_a.push_back(op_a_i);
                q_b.push_back(op_b_i);
                q_alu.push_back(op_alu_i);
                q_br.push_back(op_br_i);
                q_pc.push_back(op_pc_i);
                q_imm.push_back(op_imm_i);
            end
        end
        pending_o = q_a.size();
    end

endmodule

/* dv/ex_unit_tb.sv */
`timescale 1ns/1ps

module ex_unit_tb import ex_pkg::*; ();

    localparam int KIND_ANY    = 0;
    localparam int KIND_ALU    = 1;
    localparam int KIND_BRANCH = 2;
    localparam int TOTAL_OPS   = 2 + 300 + 200 + 150 + 100;
    // generous cycles per op, back-pressure included
    localparam int WATCHDOG_NS = TOTAL_OPS * 60 * 10;

    logic            clk_i;
    logic            rst_n_i;
    logic            op_valid_i;
    logic [XLEN-1:0] op_a_i;
    logic [XLEN-1:0] op_b_i;
    alu_op_e         op_alu_i;
    br_op_e          op_br_i;
    logic [XLEN-1:0] op_pc_i;
    logic [XLEN-1:0] op_imm_i;
    logic            op_credit_o;
    logic            res_valid_o;
    logic [XLEN-1:0] res_data_o;
    logic            res_redirect_o;
    logic [XLEN-1:0] res_target_o;
    logic            res_credit_i;

    int seed = 32'h958c6ddd;
    int issue_credits;
    int owed;
    int sent_total;
    int tb_errors;
    int tests_failed;
    int chk_errors;
    int checked;
    int credit_pulses;
    int pending;

    ex_unit uut (.*);

    ex_checker u_checker (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .op_valid_i (op_valid_i),
        .op_a_i (op_a_i), .op_b_i (op_b_i), .op_alu_i (op_alu_i), .op_br_i (op_br_i),
        .op_pc_i (op_pc_i), .op_imm_i (op_imm_i), .op_credit_i (op_credit_o),
        .res_valid_i (res_valid_o), .res_data_i (res_data_o),
        .res_redirect_i (res_redirect_o), .res_target_i (res_target_o),
        .res_credit_i (res_credit_i), .err_count_o (chk_errors), .checked_o (checked),
        .credit_pulses_o (credit_pulses), .pending_o (pending)
    );

    always #5 clk_i = ~clk_i;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [XLEN-1:0] corner(input int sel);
        case (sel)
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'h7fff_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    task automatic gen_op(input int kind);
        int r;
        op_a_i = $random(seed);
        op_b_i = $random(seed);
        // branches lean on equal and sign-only pairs
        r = (kind == KIND_BRANCH) ? pick(5) : pick(8);
        case (r)
            0: op_b_i = op_a_i;
            1: op_b_i = op_a_i ^ 32'h8000_0000;
            2: begin
                op_a_i = corner(pick(4));
                op_b_i = corner(pick(4));
            end
            3: op_b_i[SHAMT_W-1:0] = '0;
            4: op_b_i[SHAMT_W-1:0] = '1;
            default: ;
        endcase
        op_alu_i = alu_op_e'(pick(16));
        op_br_i  = (kind == KIND_ALU) ? BR_NONE : br_op_e'(pick(8));
        op_pc_i  = {$random(seed)} & 32'hffff_fffc;
        op_imm_i = $random(seed);
    endtask

    // one falling edge: collect pulses, return credits, maybe issue
    task automatic tick(input bit want_send, input int kind, input int ret_pct,
                        output bit sent);
        @(negedge clk_i);
        sent = 1'b0;
        if (op_credit_o) begin
            issue_credits++;
        end
        if (issue_credits < 0 || issue_credits > OP_QUEUE_DEPTH) begin
            $display("%0t: issue credit count out of range at %0d", $time, issue_credits);
            tb_errors++;
        end
        if (res_valid_o) begin
            owed++;
        end
        res_credit_i = 1'b0;
        if (owed > 0 && pick(100) < ret_pct) begin
            res_credit_i = 1'b1;
            owed--;
        end
        op_valid_i = 1'b0;
        if (want_send && issue_credits > 0) begin
            gen_op(kind);
            op_valid_i = 1'b1;
            issue_credits--;
            sent_total++;
            sent = 1'b1;
        end
    endtask

    task automatic drain();
        bit sent;
        while (issue_credits != OP_QUEUE_DEPTH || owed != 0 || pending != 0 || res_valid_o) begin
            tick(1'b0, KIND_ANY, 100, sent);
        end
        tick(1'b0, KIND_ANY, 100, sent);
        if (credit_pulses != sent_total) begin
            $display("credit pulses %0d do not match ops sent %0d", credit_pulses, sent_total);
            tb_errors++;
        end
    endtask

    task automatic report(input string name, input int n, input int base);
        int errs;
        errs = tb_errors + chk_errors - base;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("%-14s %s  ops=%0d errors=%0d", name, (errs == 0) ? "ok" : "FAILED", n, errs);
    endtask

    task automatic run_ops(input string name, input int n, input int kind, input int ret_pct);
        int base;
        int done;
        bit sent;
        base = tb_errors + chk_errors;
        done = 0;
        while (done < n) begin
            tick(pick(100) < 75, kind, ret_pct, sent);
            done += int'(sent);
        end
        drain();
        report(name, n, base);
    endtask

    task automatic reset_test();
        int base;
        int guard;
        bit sent;
        base = tb_errors + chk_errors;
        repeat (5) begin
            @(negedge clk_i);
            if (res_valid_o || op_credit_o) begin
                $display("%0t: outputs active during reset", $time);
                tb_errors++;
            end
        end
        rst_n_i = 1'b1;
        repeat (3) begin
            @(negedge clk_i);
            if (res_valid_o || op_credit_o) begin
                $display("%0t: outputs active right after reset", $time);
                tb_errors++;
            end
        end
        // RES_CREDITS results must flow with no credit returned
        tick(1'b1, KIND_ANY, 0, sent);
        tick(1'b1, KIND_ANY, 0, sent);
        guard = 0;
        while (checked < RES_CREDITS && guard < 20) begin
            tick(1'b0, KIND_ANY, 0, sent);
            guard++;
        end
        if (checked < RES_CREDITS) begin
            $display("initial results did not flow without credit returns");
            tb_errors++;
        end
        drain();
        report("reset", 2, base);
    endtask

    initial begin
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        op_valid_i = 1'b0;
        op_a_i = '0;
        op_b_i = '0;
        op_alu_i = ALU_ADD;
        op_br_i = BR_NONE;
        op_pc_i = '0;
        op_imm_i = '0;
        res_credit_i = 1'b0;
        issue_credits = OP_QUEUE_DEPTH;
        reset_test();
        run_ops("alu", 300, KIND_ALU, 60);
        run_ops("branch", 200, KIND_BRANCH, 60);
        run_ops("backpressure", 150, KIND_ANY, 3);
        run_ops("upstream", 100, KIND_ANY, 80);
        $display("tests=5 failed=%0d results=%0d errors=%0d",
                 tests_failed, checked, tb_errors + chk_errors);
        if (tests_failed == 0 && tb_errors + chk_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu import ex_pkg::*; (
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  alu_op_e         op_i,
    output logic [XLEN-1:0] result_o
);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;

    // shift amount from low bits of operand b
    assign shamt = b_i[SHAMT_W-1:0];

    // two's-complement compare
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                result_o = a_i + b_i;
            end
            ALU_SUB: begin
                result_o = a_i - b_i;
            end
            ALU_AND: begin
                result_o = a_i & b_i;
            end
            ALU_OR: begin
                result_o = a_i | b_i;
            end
            ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            ALU_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_s};
            end
            ALU_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_u};
            end
            // logical shifts only
            ALU_SRL: begin
                result_o = a_i >> shamt;
            end
            ALU_SLL: begin
                result_o = a_i << shamt;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* logic/branch_cmp.sv */
`timescale 1ns/1ps

module branch_cmp import ex_pkg::*; (
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  br_op_e          op_i,
    output logic            taken_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    // shared comparators for all branch kinds
    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (op_i)
            BR_BEQ: begin
                taken_o = eq;
            end
            BR_BNE: begin
                taken_o = !eq;
            end
            BR_BLT: begin
                taken_o = lt_s;
            end
            BR_BGE: begin
                taken_o = !lt_s;
            end
            BR_BLTU: begin
                taken_o = lt_u;
            end
            BR_BGEU: begin
                taken_o = !lt_u;
            end
            // unconditional jump
            BR_JAL: begin
                taken_o = 1'b1;
            end
            default: begin
                taken_o = 1'b0;
            end
        endcase
    end

endmodule

/* logic/ex_combine.sv */
`timescale 1ns/1ps

module ex_combine import ex_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            head_valid_i,
    input  br_op_e          head_br_op_i,
    input  logic [XLEN-1:0] head_pc_i,
    input  logic [XLEN-1:0] head_imm_i,
    input  logic [XLEN-1:0] alu_result_i,
    input  logic            taken_i,
    input  logic            res_credit_i,
    output logic            pop_o,
    output logic            res_valid_o,
    output logic [XLEN-1:0] res_data_o,
    output logic            res_redirect_o,
    output logic [XLEN-1:0] res_target_o
);

    logic [RCRD_W-1:0] credit_cnt;
    logic              has_credit;
    logic [XLEN-1:0]   link_addr;
    logic [XLEN-1:0]   dest_val;
    logic [XLEN-1:0]   target;

    assign has_credit = (credit_cnt != '0);

    // advance only when writeback can take the result
    assign pop_o = head_valid_i && has_credit;

    // jal writes the return address
    assign link_addr = head_pc_i + XLEN'(4);
    assign dest_val  = (head_br_op_i == BR_JAL) ? link_addr : alu_result_i;
    assign target    = head_pc_i + head_imm_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= pop_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            res_data_o     <= dest_val;
            res_redirect_o <= taken_i;
            res_target_o   <= target;
        end
    end

    // downstream credits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_cnt <= RCRD_W'(RES_CREDITS);
        end else begin
            case ({pop_o, res_credit_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // writeback returns no more than it was given
    a_credit_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (res_credit_i && !pop_o) |-> (credit_cnt < RCRD_W'(RES_CREDITS)))
        else $error("ex_combine: credit return above RES_CREDITS");

endmodule

/* logic/ex_pkg.sv */
package ex_pkg;

    // datapath widths
    localparam int XLEN    = 32;
    localparam int SHAMT_W = 5;

    // issue side queue, also the initial issue credit count
    localparam int OP_QUEUE_DEPTH = 4;
    localparam int QPTR_W         = $clog2(OP_QUEUE_DEPTH);
    localparam int QCNT_W         = $clog2(OP_QUEUE_DEPTH + 1);

    // results the writeback side can hold
    localparam int RES_CREDITS = 2;
    localparam int RCRD_W      = $clog2(RES_CREDITS + 1);

    // alu control codes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SLT  = 4'b0101,
        ALU_SLTU = 4'b0110,
        ALU_SRL  = 4'b0111,
        ALU_SLL  = 4'b1000,
        ALU_R9   = 4'b1001,
        ALU_R10  = 4'b1010,
        ALU_R11  = 4'b1011,
        ALU_R12  = 4'b1100,
        ALU_R13  = 4'b1101,
        ALU_R14  = 4'b1110,
        ALU_R15  = 4'b1111
    } alu_op_e;

    // branch codes
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_BLT  = 3'd3,
        BR_BGE  = 3'd4,
        BR_BLTU = 3'd5,
        BR_BGEU = 3'd6,
        BR_JAL  = 3'd7
    } br_op_e;

endpackage

/* logic/ex_unit.sv */
`timescale 1ns/1ps

module ex_unit import ex_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            op_valid_i,
    input  logic [XLEN-1:0] op_a_i,
    input  logic [XLEN-1:0] op_b_i,
    input  alu_op_e         op_alu_i,
    input  br_op_e          op_br_i,
    input  logic [XLEN-1:0] op_pc_i,
    input  logic [XLEN-1:0] op_imm_i,
    output logic            op_credit_o,
    output logic            res_valid_o,
    output logic [XLEN-1:0] res_data_o,
    output logic            res_redirect_o,
    output logic [XLEN-1:0] res_target_o,
    input  logic            res_credit_i
);

    logic            head_valid;
    logic [XLEN-1:0] head_a;
    logic [XLEN-1:0] head_b;
    alu_op_e         head_alu_op;
    br_op_e          head_br_op;
    logic [XLEN-1:0] head_pc;
    logic [XLEN-1:0] head_imm;
    logic            pop;
    logic [XLEN-1:0] alu_result;
    logic            br_taken;

    op_queue u_op_queue (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .wr_i          (op_valid_i),
        .a_i           (op_a_i),
        .b_i           (op_b_i),
        .alu_op_i      (op_alu_i),
        .br_op_i       (op_br_i),
        .pc_i          (op_pc_i),
        .imm_i         (op_imm_i),
        .pop_i         (pop),
        .head_valid_o  (head_valid),
        .head_a_o      (head_a),
        .head_b_o      (head_b),
        .head_alu_op_o (head_alu_op),
        .head_br_op_o  (head_br_op),
        .head_pc_o     (head_pc),
        .head_imm_o    (head_imm),
        .credit_o      (op_credit_o)
    );

    // both answers worked out on the queue head
    alu u_alu (
        .a_i      (head_a),
        .b_i      (head_b),
        .op_i     (head_alu_op),
        .result_o (alu_result)
    );

    branch_cmp u_branch_cmp (
        .a_i     (head_a),
        .b_i     (head_b),
        .op_i    (head_br_op),
        .taken_o (br_taken)
    );

    ex_combine u_ex_combine (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .head_valid_i   (head_valid),
        .head_br_op_i   (head_br_op),
        .head_pc_i      (head_pc),
        .head_imm_i     (head_imm),
        .alu_result_i   (alu_result),
        .taken_i        (br_taken),
        .res_credit_i   (res_credit_i),
        .pop_o          (pop),
        .res_valid_o    (res_valid_o),
        .res_data_o     (res_data_o),
        .res_redirect_o (res_redirect_o),
        .res_target_o   (res_target_o)
    );

endmodule

/* logic/op_queue.sv */
`timescale 1ns/1ps

module op_queue import ex_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             wr_i,
    input  logic [XLEN-1:0]  a_i,
    input  logic [XLEN-1:0]  b_i,
    input  alu_op_e          alu_op_i,
    input  br_op_e           br_op_i,
    input  logic [XLEN-1:0]  pc_i,
    input  logic [XLEN-1:0]  imm_i,
    input  logic             pop_i,
    output logic             head_valid_o,
    output logic [XLEN-1:0]  head_a_o,
    output logic [XLEN-1:0]  head_b_o,
    output alu_op_e          head_alu_op_o,
    output br_op_e           head_br_op_o,
    output logic [XLEN-1:0]  head_pc_o,
    output logic [XLEN-1:0]  head_imm_o,
    output logic             credit_o
);

    logic [XLEN-1:0]   mem_a   [OP_QUEUE_DEPTH];
    logic [XLEN-1:0]   mem_b   [OP_QUEUE_DEPTH];
    alu_op_e           mem_alu [OP_QUEUE_DEPTH];
    br_op_e            mem_br  [OP_QUEUE_DEPTH];
    logic [XLEN-1:0]   mem_pc  [OP_QUEUE_DEPTH];
    logic [XLEN-1:0]   mem_imm [OP_QUEUE_DEPTH];

    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;
    logic              full;

    assign full         = (count == QCNT_W'(OP_QUEUE_DEPTH));
    assign head_valid_o = (count != '0);

    assign head_a_o      = mem_a[rd_ptr];
    assign head_b_o      = mem_b[rd_ptr];
    assign head_alu_op_o = mem_alu[rd_ptr];
    assign head_br_op_o  = mem_br[rd_ptr];
    assign head_pc_o     = mem_pc[rd_ptr];
    assign head_imm_o    = mem_imm[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            mem_a[wr_ptr]   <= a_i;
            mem_b[wr_ptr]   <= b_i;
            mem_alu[wr_ptr] <= alu_op_i;
            mem_br[wr_ptr]  <= br_op_i;
            mem_pc[wr_ptr]  <= pc_i;
            mem_imm[wr_ptr] <= imm_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (wr_i) begin
                wr_ptr <= (wr_ptr == QPTR_W'(OP_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == QPTR_W'(OP_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back to issue per departed op
            credit_o <= pop_i;
        end
    end

    // issue side must hold a credit for every write
    a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_i |-> !full)
        else $error("op_queue: write into full queue");

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> head_valid_o)
        else $error("op_queue: pop from empty queue");

endmodule

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f sources.f \
    --top-module ex_unit_tb \
    -o ex_sim

./obj_dir/ex_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
    exit 1
fi

grep -q "All tests passed!" sim.log

/* sources.f */
logic/ex_pkg.sv
logic/op_queue.sv
logic/alu.sv
logic/branch_cmp.sv
logic/ex_combine.sv
logic/ex_unit.sv
dv/ex_checker.sv
dv/ex_unit_tb.sv
